// ==== tb.f ====
hdl/pkt_gate_pkg.sv
hdl/pkt_ram_if.sv
hdl/pkt_buffer.sv
hdl/end_addr_fifo.sv
hdl/pkt_writer.sv
hdl/pkt_reader.sv
hdl/pkt_gate_top.sv
bench/pkt_gate_assert.sv
bench/pkt_gate_tb.sv

// ==== Bender.yml ====
package:
  name: pkt_gate

sources:
  # RTL in compile order
  - hdl/pkt_gate_pkg.sv
  - hdl/pkt_ram_if.sv
  - hdl/pkt_buffer.sv
  - hdl/end_addr_fifo.sv
  - hdl/pkt_writer.sv
  - hdl/pkt_reader.sv
  - hdl/pkt_gate_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/pkt_gate_assert.sv
      - bench/pkt_gate_tb.sv

// ==== bench/pkt_gate_tb.sv ====
`timescale 1ns/10ps

module pkt_gate_tb import pkt_gate_pkg::*; ();

  // Upper bound on packets over all tests
  localparam int NUM_PKTS   = 100;
  // Four clock periods for every beat of a maximum packet, plus idle tails
  localparam int TIMEOUT_NS = NUM_PKTS * 16 * 4 * 20 + 10000;

  logic              clk = 1'b0;
  logic              i_rst_n;
  logic              i_clear;
  logic [DATA_W-1:0] i_tdata;
  logic              i_tlast;
  logic              i_terror;
  logic              i_tvalid;
  logic              o_tready_in;
  logic [DATA_W-1:0] o_tdata;
  logic              o_tlast;
  logic              o_tvalid;
  logic              i_tready_out;

  // Separate generator states for the input side and the output stalls
  logic [31:0]       gen_seed   = 32'h3020;
  logic [31:0]       stall_seed = ~32'h3020;
  // 0 keeps downstream ready, 1 stalls at random, 2 holds it stalled
  int                out_mode;
  logic              stall_seen;
  // Beats of the packet still arriving, and beats due at the output
  logic [WORD_W-1:0] open_q [$];
  logic [WORD_W-1:0] exp_q  [$];

  always #10 clk = ~clk;

  pkt_gate_top dut (.*);

  // --------------------------------------------------
  // Random numbers and the reference model
  // --------------------------------------------------

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  // Only the upper bits are used because the low LCG bits repeat with short periods
  function automatic int pick(inout logic [31:0] state, input int n);
    logic [31:0] r;
    r = lcg_next(state);
    return int'(r[31:16]) % n;
  endfunction

  // A packet is released only once its last beat arrives clean
  function automatic void model_accept(input logic [DATA_W-1:0] data, input logic last,
                                       input logic err);
    open_q.push_back({last, data});
    if (last) begin
      if (!err) begin
        foreach (open_q[k]) exp_q.push_back(open_q[k]);
      end
      open_q.delete();
    end
  endfunction

  // --------------------------------------------------
  // Failure reporting and checks
  // --------------------------------------------------

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_data(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAILED at %0t: o_tdata is %h, expected %h", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic check_last(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: o_tlast is %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  // Starts on a falling edge and returns on the falling edge after the beat is taken
  task automatic send_beat(input logic [DATA_W-1:0] data, input logic last, input logic err);
    logic taken;
    i_tdata  = data;
    i_tlast  = last;
    i_terror = err;
    i_tvalid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      @(posedge clk);
      taken = o_tready_in;
      @(negedge clk);
    end
    i_tvalid = 1'b0;
  endtask

  // Inserts random gaps between beats and holds the last beat back by hold cycles
  task automatic send_pkt(input int len, input logic err, input int hold);
    int gap;
    for (int i = 0; i < len; i++) begin
      gap = (pick(gen_seed, 4) == 0) ? 1 + pick(gen_seed, 3) : 0;
      repeat (gap) @(negedge clk);
      if (i == len - 1) repeat (hold) @(negedge clk);
      send_beat(lcg_next(gen_seed), i == len - 1, err && (i == len - 1));
    end
  endtask

  always @(negedge clk) begin
    case (out_mode)
      0:       i_tready_out = 1'b1;
      1:       i_tready_out = (pick(stall_seed, 4) != 0);
      default: i_tready_out = 1'b0;
    endcase
  end

  // The input monitor feeds the model and drops everything in a clear cycle as the gate does
  always @(posedge clk) begin
    if (i_clear) begin
      open_q.delete();
      exp_q.delete();
    end else if (i_rst_n && i_tvalid && o_tready_in) begin
      model_accept(i_tdata, i_tlast, i_terror);
    end
  end

  // Compare every output transfer with the head of the expected queue
  always @(posedge clk) begin
    logic [WORD_W-1:0] exp;
    if (i_rst_n && !i_clear && o_tvalid && i_tready_out) begin
      if (exp_q.size() == 0) begin
        $display("An output beat appeared at %0t when no beat was expected", $time);
        abort_run();
      end else begin
        exp = exp_q.pop_front();
        check_data(o_tdata, exp[DATA_W-1:0]);
        check_last(o_tlast, exp[DATA_W]);
      end
    end
  end

  // Stop as soon as a bound output stream assertion has fired
  always @(posedge clk) begin
    if (dut.u_assert.fail_cnt != 0) begin
      $display("An output stream assertion failed before %0t", $time);
      abort_run();
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: traffic did not drain within %0d ns", TIMEOUT_NS);
    abort_run();
  end

  initial begin
    i_rst_n      = 1'b0;
    i_clear      = 1'b0;
    i_tdata      = '0;
    i_tlast      = 1'b0;
    i_terror     = 1'b0;
    i_tvalid     = 1'b0;
    i_tready_out = 1'b0;
    out_mode     = 0;
    stall_seen   = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    i_rst_n = 1'b1;

    // Clean packets and then a mix with errored packets while downstream stays ready
    repeat (20) send_pkt(1 + pick(gen_seed, 16), 1'b0, 0);
    repeat (20) send_pkt(1 + pick(gen_seed, 16), pick(gen_seed, 3) == 0, 0);
    // Same mix under random output stalls
    out_mode <= 1;
    repeat (30) send_pkt(1 + pick(gen_seed, 16), pick(gen_seed, 4) == 0, 0);

    // Stall downstream until the input side backs up and then release it
    out_mode <= 2;
    fork
      repeat (6) send_pkt(6, 1'b0, 0);
      begin
        while (!stall_seen) begin
          @(posedge clk);
          stall_seen = i_tvalid && !o_tready_in;
        end
        repeat (10) @(negedge clk);
        out_mode <= 1;
      end
    join

    // A packet held open before its last beat with nothing else pending
    out_mode <= 0;
    while (exp_q.size() != 0) @(negedge clk);
    send_pkt(12, 1'b0, 30);
    send_pkt(16, 1'b0, 20);

    // Clear with data buffered and the output register loaded
    while (exp_q.size() != 0) @(negedge clk);
    out_mode <= 2;
    repeat (3) send_pkt(4, 1'b0, 0);
    repeat (4) @(negedge clk);
    i_clear = 1'b1;
    @(negedge clk);
    i_clear = 1'b0;
    out_mode <= 1;
    repeat (13) send_pkt(1 + pick(gen_seed, 16), pick(gen_seed, 4) == 0, 0);

    out_mode <= 0;
    while (exp_q.size() != 0) @(negedge clk);
    repeat (20) @(negedge clk);
    if (dut.u_assert.fail_cnt != 0) begin
      $display("An output stream assertion failed during the run");
      abort_run();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== bench/pkt_gate_assert.sv ====
`timescale 1ns/10ps

// Output stream protocol checks for the packet gate
module pkt_gate_assert import pkt_gate_pkg::*; (
  input logic              clk,
  input logic              i_rst_n,
  input logic              i_clear,
  input logic [DATA_W-1:0] o_tdata,
  input logic              o_tlast,
  input logic              o_tvalid,
  input logic              i_tready_out
);

  // Number of assertion failures seen so far
  int fail_cnt = 0;

  // The output register leaves reset empty
  a_reset_idle: assert property (@(posedge clk) $rose(i_rst_n) |-> !o_tvalid)
    else begin
      $error("o_tvalid is high in the first cycle after reset");
      fail_cnt = fail_cnt + 1;
    end

  // A stalled beat keeps its valid, data and last flag
  a_hold: assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
    (o_tvalid && !i_tready_out) |=> (o_tvalid && $stable(o_tdata) && $stable(o_tlast)))
    else begin
      $error("Output beat changed while downstream was stalled");
      fail_cnt = fail_cnt + 1;
    end

  // Inside a packet the beats leave back to back while downstream stays ready
  a_no_gap: assert property (@(posedge clk) disable iff (!i_rst_n || i_clear)
    (o_tvalid && i_tready_out && !o_tlast) ##1 i_tready_out |-> o_tvalid)
    else begin
      $error("o_tvalid dropped inside a packet with downstream ready");
      fail_cnt = fail_cnt + 1;
    end

endmodule

bind pkt_gate_top pkt_gate_assert u_assert (.*);

// ==== hdl/pkt_gate_top.sv ====
`timescale 1ns/10ps

// Packet gate: releases a packet only after it has fully and cleanly arrived
module pkt_gate_top import pkt_gate_pkg::*; (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_clear,
  // Input stream
  input  logic [DATA_W-1:0] i_tdata,
  input  logic              i_tlast,
  input  logic              i_terror,
  input  logic              i_tvalid,
  output logic              o_tready_in,
  // Output stream
  output logic [DATA_W-1:0] o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  logic              i_tready_out
);

  // Buffer flags
  logic              full;
  logic              empty;
  // End-address FIFO push side
  logic [ADDR_W-1:0] push_addr;
  logic              push_valid;
  logic              push_ready;
  // End-address FIFO pop side
  logic [ADDR_W-1:0] end_addr;
  logic              end_valid;
  logic              end_ready;

  pkt_ram_if ram_if ();

  pkt_buffer u_buffer (
    .clk, .i_rst_n, .i_clear,
    .ram     (ram_if.buffer),
    .o_full  (full),
    .o_empty (empty)
  );

  end_addr_fifo u_end_fifo (
    .clk, .i_rst_n, .i_clear,
    .i_push_addr  (push_addr),  .i_push_valid (push_valid), .o_push_ready (push_ready),
    .o_pop_addr   (end_addr),   .o_pop_valid  (end_valid),  .i_pop_ready  (end_ready)
  );

  pkt_writer u_writer (
    .clk, .i_rst_n, .i_clear,
    .i_tdata, .i_tlast, .i_terror, .i_tvalid,
    .o_tready     (o_tready_in),
    .i_full       (full),
    .ram          (ram_if.writer),
    .o_push_addr  (push_addr),  .o_push_valid (push_valid), .i_push_ready (push_ready)
  );

  pkt_reader u_reader (
    .clk, .i_rst_n, .i_clear,
    .i_empty     (empty),
    .ram         (ram_if.reader),
    .i_end_addr  (end_addr),   .i_end_valid (end_valid),  .o_end_ready (end_ready),
    .o_tdata, .o_tlast, .o_tvalid,
    .i_tready    (i_tready_out)
  );

endmodule

// ==== hdl/pkt_reader.sv ====
`timescale 1ns/10ps

// Output side of the gate: drains complete packets through an output register
module pkt_reader import pkt_gate_pkg::*; (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_clear,
  input  logic              i_empty,
  pkt_ram_if.reader         ram,
  input  logic [ADDR_W-1:0] i_end_addr,
  input  logic              i_end_valid,
  output logic              o_end_ready,
  output logic [DATA_W-1:0] o_tdata,
  output logic              o_tlast,
  output logic              o_tvalid,
  input  logic              i_tready
);

  // --------------------------------------------------
  // Read stage
  // --------------------------------------------------

  logic [ADDR_W-1:0] rd_addr_q;
  logic              rd_valid_q;
  logic              update_out;
  logic              ready_to_read;
  logic              rd_go;

  // The output register can load when it is empty or its word is leaving
  assign update_out = i_tready | ~o_tvalid;

  // A queued end address means a whole packet sits in the buffer
  assign ready_to_read = ~i_empty & i_end_valid;
  assign rd_go         = ready_to_read & (update_out | ~rd_valid_q);

  assign ram.rd_en   = rd_go;
  assign ram.rd_addr = rd_addr_q;

  // Retire the end address together with the packet's last line
  assign o_end_ready = rd_go & (i_end_addr == rd_addr_q);

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rd_addr_q  <= '0;
      rd_valid_q <= 1'b0;
    end else if (i_clear) begin
      rd_addr_q  <= '0;
      rd_valid_q <= 1'b0;
    end else if (update_out || !rd_valid_q) begin
      rd_valid_q <= ready_to_read;
      if (ready_to_read) begin
        rd_addr_q <= rd_addr_q + ADDR_W'(1);
      end
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  // Holds its word under back-pressure
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_tvalid <= 1'b0;
    end else if (i_clear) begin
      o_tvalid <= 1'b0;
    end else if (update_out) begin
      o_tvalid <= rd_valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (update_out) begin
      {o_tlast, o_tdata} <= ram.rd_data;
    end
  end

endmodule

// ==== hdl/pkt_writer.sv ====
`timescale 1ns/10ps

// Input side of the gate: stores beats and commits or drops whole packets
module pkt_writer import pkt_gate_pkg::*; (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_clear,
  input  logic [DATA_W-1:0] i_tdata,
  input  logic              i_tlast,
  input  logic              i_terror,
  input  logic              i_tvalid,
  output logic              o_tready,
  input  logic              i_full,
  pkt_ram_if.writer         ram,
  output logic [ADDR_W-1:0] o_push_addr,
  output logic              o_push_valid,
  input  logic              i_push_ready
);

  // Next free line and first line of the packet being built
  logic [ADDR_W-1:0] wr_addr_q;
  logic [ADDR_W-1:0] head_addr_q;
  logic              accept;
  logic              bad_last;

  // A beat is only taken when it can be stored and its end address can be queued
  assign o_tready = ~i_full & i_push_ready;
  assign accept   = i_tvalid & o_tready;
  assign bad_last = i_tlast & i_terror;

  // The errored last beat is thrown away so it never touches the occupancy flags
  assign ram.wr_en   = accept & ~bad_last;
  assign ram.wr_addr = wr_addr_q;
  assign ram.wr_data = {i_tlast, i_tdata};

  // Push the end address with a good last beat
  assign o_push_addr  = wr_addr_q;
  assign o_push_valid = i_tvalid & i_tlast & ~i_terror & ~i_full;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_addr_q   <= '0;
      head_addr_q <= '0;
    end else if (i_clear) begin
      wr_addr_q   <= '0;
      head_addr_q <= '0;
    end else if (accept) begin
      if (bad_last) begin
        // Rewind so the packet was never there
        wr_addr_q <= head_addr_q;
      end else if (i_tlast) begin
        wr_addr_q   <= wr_addr_q + ADDR_W'(1);
        head_addr_q <= wr_addr_q + ADDR_W'(1);
      end else begin
        wr_addr_q <= wr_addr_q + ADDR_W'(1);
      end
    end
  end

endmodule

// ==== hdl/end_addr_fifo.sv ====
`timescale 1ns/10ps

// Circular FIFO holding the last buffer address of every complete packet
module end_addr_fifo import pkt_gate_pkg::*; (
  input  logic              clk,
  input  logic              i_rst_n,
  input  logic              i_clear,
  input  logic [ADDR_W-1:0] i_push_addr,
  input  logic              i_push_valid,
  output logic              o_push_ready,
  output logic [ADDR_W-1:0] o_pop_addr,
  output logic              o_pop_valid,
  input  logic              i_pop_ready
);

  logic [ADDR_W-1:0] mem [2**AFIFO_AW];

  // The extra top bit tells a full FIFO from an empty one
  logic [AFIFO_AW:0] wr_ptr;
  logic [AFIFO_AW:0] rd_ptr;
  logic              push;
  logic              pop;

  // Full when the pointers differ only in the wrap bit
  assign o_push_ready = ((wr_ptr ^ rd_ptr) != {1'b1, {AFIFO_AW{1'b0}}});
  assign o_pop_valid  = (wr_ptr != rd_ptr);
  assign push         = i_push_valid & o_push_ready;
  assign pop          = o_pop_valid & i_pop_ready;

  // Head entry is read straight from the array
  assign o_pop_addr = mem[rd_ptr[AFIFO_AW-1:0]];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AFIFO_AW-1:0]] <= i_push_addr;
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (i_clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

// ==== hdl/pkt_buffer.sv ====
`timescale 1ns/10ps

// Simple dual-port packet storage with occupancy flags
module pkt_buffer import pkt_gate_pkg::*; (
  input  logic      clk,
  input  logic      i_rst_n,
  input  logic      i_clear,
  pkt_ram_if.buffer ram,
  output logic      o_full,
  output logic      o_empty
);

  // --------------------------------------------------
  // Storage array
  // --------------------------------------------------

  logic [WORD_W-1:0] mem [BUF_DEPTH];

  // One write port and one registered read port
  // The read word holds its value while rd_en is low
  always_ff @(posedge clk) begin
    if (ram.wr_en) begin
      mem[ram.wr_addr] <= ram.wr_data;
    end
    if (ram.rd_en) begin
      ram.rd_data <= mem[ram.rd_addr];
    end
  end

  // --------------------------------------------------
  // Full and empty flags
  // --------------------------------------------------

  // Both full and empty have equal pointers
  // The flags look one step ahead to tell which side the pointers meet from
  logic almost_full;
  logic almost_empty;

  assign almost_full  = (ram.wr_addr == ram.rd_addr - ADDR_W'(1));
  assign almost_empty = (ram.wr_addr == ram.rd_addr + ADDR_W'(1));

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_full  <= 1'b0;
      o_empty <= 1'b1;
    end else if (i_clear) begin
      o_full  <= 1'b0;
      o_empty <= 1'b1;
    end else begin
      // A lone write into the last free line fills the buffer
      if (almost_full) begin
        if (ram.wr_en && !ram.rd_en) begin
          o_full <= 1'b1;
        end
      end else if (!ram.wr_en && ram.rd_en) begin
        o_full <= 1'b0;
      end
      // A lone read of the last stored line empties it
      if (almost_empty) begin
        if (ram.rd_en && !ram.wr_en) begin
          o_empty <= 1'b1;
        end
      end else if (ram.wr_en && !ram.rd_en) begin
        o_empty <= 1'b0;
      end
    end
  end

endmodule

// ==== hdl/pkt_ram_if.sv ====
`timescale 1ns/10ps

// Write and read ports of the packet buffer
// The writer owns the write side and the reader owns the read side
interface pkt_ram_if import pkt_gate_pkg::*; ();

  // Write port, one word per accepted input beat
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  logic [WORD_W-1:0] wr_data;

  // Read port, data comes back one edge after rd_en
  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  logic [WORD_W-1:0] rd_data;

  modport writer (
    output wr_en, wr_addr, wr_data
  );

  modport reader (
    output rd_en, rd_addr,
    input  rd_data
  );

  modport buffer (
    input  wr_en, wr_addr, wr_data, rd_en, rd_addr,
    output rd_data
  );

endinterface

// ==== hdl/pkt_gate_pkg.sv ====
package pkt_gate_pkg;

  // --------------------------------------------------
  // Datapath sizes
  // --------------------------------------------------

  // Width of one data beat on both streams
  localparam int DATA_W = 32;

  // Buffer address width, so the buffer holds 2**ADDR_W lines
  // The largest packet that can pass is one full buffer
  localparam int ADDR_W = 4;
  localparam int BUF_DEPTH = 16;

  // A stored word keeps the last flag in its top bit
  localparam int WORD_W = DATA_W + 1;

  // --------------------------------------------------
  // End-address FIFO
  // --------------------------------------------------

  // Deep enough to track a buffer full of single-beat packets
  localparam int AFIFO_AW = 4;

endpackage
